// ==== hdl/axi_lite_consts.svh ====
/*
  Widths and sizes for the AXI4-Lite link. Data width must be a multiple of 8,
  and the register count a power of two.
*/
`ifndef AXI_LITE_CONSTS_SVH
`define AXI_LITE_CONSTS_SVH

// Bus widths
`define AXIL_ADDR_WIDTH 32
`define AXIL_DATA_WIDTH 32

// Register file depth in words
`define AXIL_NUM_REGS 16

// Register cuts between the top ports and the register file
`define AXIL_NUM_CUTS 2

`endif

// ==== hdl/axi_lite_pkg.sv ====
/*
  AXI4-Lite types for the link. No IDs, bursts or user bits.
  Prot is carried through the link but not interpreted anywhere.
*/
`include "axi_lite_consts.svh"

package axi_lite_pkg;

  typedef logic [`AXIL_ADDR_WIDTH-1:0]   addr_t;
  typedef logic [`AXIL_DATA_WIDTH-1:0]   data_t;
  typedef logic [`AXIL_DATA_WIDTH/8-1:0] strb_t;
  typedef logic [2:0]                    prot_t;
  typedef logic [1:0]                    resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Channel payloads
  typedef struct packed {addr_t addr; prot_t prot;} aw_chan_t;
  typedef struct packed {data_t data; strb_t strb;} w_chan_t;
  typedef struct packed {resp_t resp;} b_chan_t;
  typedef struct packed {addr_t addr; prot_t prot;} ar_chan_t;
  typedef struct packed {data_t data; resp_t resp;} r_chan_t;

  // Manager to subordinate
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axil_req_t;

  // Subordinate to manager
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axil_rsp_t;

endpackage

// ==== hdl/spill_register.sv ====
/*
  Two-entry valid/ready stage. Both ready_o and valid_o are registered.
  Adds one cycle of latency, full throughput without back-pressure.
*/
module spill_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic a_full_q;
  logic b_full_q;
  T     a_data_q;
  T     b_data_q;

  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  // Slot A takes new items, slot B parks an item that stalled at the output
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
    end else if (a_fill || a_drain) begin
      a_full_q <= a_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_full_q <= 1'b0;
    end else if (b_fill || b_drain) begin
      b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // Older item sits in B whenever B is full
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  // Room left as long as one slot is free
  assign ready_o = !a_full_q || !b_full_q;

endmodule

// ==== hdl/axi_lite_cut.sv ====
/*
  One register cut on all five AXI4-Lite channels.
  Every channel gets one cycle of latency and keeps full throughput.
*/
module axi_lite_cut (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axi_lite_pkg::axil_req_t sbr_req_i,
  output axi_lite_pkg::axil_rsp_t sbr_rsp_o,
  output axi_lite_pkg::axil_req_t mgr_req_o,
  input  axi_lite_pkg::axil_rsp_t mgr_rsp_i
);
  import axi_lite_pkg::*;

  // Channel signals on the far side of each spill register
  aw_chan_t aw;
  w_chan_t  w;
  ar_chan_t ar;
  b_chan_t  b;
  r_chan_t  r;
  logic     aw_valid, w_valid, ar_valid, b_valid, r_valid;
  logic     aw_ready, w_ready, ar_ready, b_ready, r_ready;

  // Forward channels
  spill_register #(.T(aw_chan_t)) i_aw_spill (
    .clk_i, .rst_i,
    .valid_i (sbr_req_i.aw_valid), .ready_o (aw_ready), .data_i (sbr_req_i.aw),
    .valid_o (aw_valid), .ready_i (mgr_rsp_i.aw_ready), .data_o (aw)
  );

  spill_register #(.T(w_chan_t)) i_w_spill (
    .clk_i, .rst_i,
    .valid_i (sbr_req_i.w_valid), .ready_o (w_ready), .data_i (sbr_req_i.w),
    .valid_o (w_valid), .ready_i (mgr_rsp_i.w_ready), .data_o (w)
  );

  spill_register #(.T(ar_chan_t)) i_ar_spill (
    .clk_i, .rst_i,
    .valid_i (sbr_req_i.ar_valid), .ready_o (ar_ready), .data_i (sbr_req_i.ar),
    .valid_o (ar_valid), .ready_i (mgr_rsp_i.ar_ready), .data_o (ar)
  );

  // Backward channels
  spill_register #(.T(b_chan_t)) i_b_spill (
    .clk_i, .rst_i,
    .valid_i (mgr_rsp_i.b_valid), .ready_o (b_ready), .data_i (mgr_rsp_i.b),
    .valid_o (b_valid), .ready_i (sbr_req_i.b_ready), .data_o (b)
  );

  spill_register #(.T(r_chan_t)) i_r_spill (
    .clk_i, .rst_i,
    .valid_i (mgr_rsp_i.r_valid), .ready_o (r_ready), .data_i (mgr_rsp_i.r),
    .valid_o (r_valid), .ready_i (sbr_req_i.r_ready), .data_o (r)
  );

  // Repack toward the manager side of the chain
  always_comb begin
    sbr_rsp_o.aw_ready = aw_ready;
    sbr_rsp_o.w_ready  = w_ready;
    sbr_rsp_o.b        = b;
    sbr_rsp_o.b_valid  = b_valid;
    sbr_rsp_o.ar_ready = ar_ready;
    sbr_rsp_o.r        = r;
    sbr_rsp_o.r_valid  = r_valid;
  end

  // Repack toward the subordinate side
  always_comb begin
    mgr_req_o.aw       = aw;
    mgr_req_o.aw_valid = aw_valid;
    mgr_req_o.w        = w;
    mgr_req_o.w_valid  = w_valid;
    mgr_req_o.b_ready  = b_ready;
    mgr_req_o.ar       = ar;
    mgr_req_o.ar_valid = ar_valid;
    mgr_req_o.r_ready  = r_ready;
  end

endmodule

// ==== hdl/axi_lite_multicut.sv ====
/*
  Chain of NumCuts AXI4-Lite cuts, NumCuts cycles per channel and direction.
  NumCuts of zero connects the ports straight through.
*/
module axi_lite_multicut #(
  parameter int unsigned NumCuts = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axi_lite_pkg::axil_req_t sbr_req_i,
  output axi_lite_pkg::axil_rsp_t sbr_rsp_o,
  output axi_lite_pkg::axil_req_t mgr_req_o,
  input  axi_lite_pkg::axil_rsp_t mgr_rsp_i
);
  import axi_lite_pkg::*;

  if (NumCuts == 0) begin : gen_bypass
    assign mgr_req_o = sbr_req_i;
    assign sbr_rsp_o = mgr_rsp_i;
  end else begin : gen_chain
    // Index 0 faces the manager, index NumCuts the subordinate
    axil_req_t [NumCuts:0] link_req;
    axil_rsp_t [NumCuts:0] link_rsp;

    assign link_req[0] = sbr_req_i;
    assign sbr_rsp_o   = link_rsp[0];

    for (genvar i = 0; i < NumCuts; i++) begin : gen_cut
      axi_lite_cut i_cut (
        .clk_i,
        .rst_i,
        .sbr_req_i (link_req[i]),
        .sbr_rsp_o (link_rsp[i]),
        .mgr_req_o (link_req[i+1]),
        .mgr_rsp_i (link_rsp[i+1])
      );
    end

    assign mgr_req_o         = link_req[NumCuts];
    assign link_rsp[NumCuts] = mgr_rsp_i;
  end

endmodule

// ==== hdl/axi_lite_regfile.sv ====
/*
  AXI4-Lite register file, one response slot each for B and R.
  Any address bit set above the register range answers SLVERR.
*/
`include "axi_lite_consts.svh"

module axi_lite_regfile (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axi_lite_pkg::axil_req_t req_i,
  output axi_lite_pkg::axil_rsp_t rsp_o
);
  import axi_lite_pkg::*;

  localparam int unsigned IdxWidth  = $clog2(`AXIL_NUM_REGS);
  localparam int unsigned ByteLanes = `AXIL_DATA_WIDTH / 8;

  typedef logic [IdxWidth-1:0] idx_t;

  data_t   regs_q [`AXIL_NUM_REGS];
  logic    b_valid_q;
  b_chan_t b_q;
  logic    r_valid_q;
  r_chan_t r_q;

  logic wr_go, rd_go;
  logic wr_err, rd_err;
  idx_t wr_idx, rd_idx;

  // Write needs AW and W together plus a free or draining B slot
  assign wr_go = req_i.aw_valid && req_i.w_valid && (!b_valid_q || req_i.b_ready);
  assign rd_go = req_i.ar_valid && (!r_valid_q || req_i.r_ready);

  // Word index from bits above the byte offset
  assign wr_idx = req_i.aw.addr[IdxWidth+1:2];
  assign rd_idx = req_i.ar.addr[IdxWidth+1:2];
  assign wr_err = |req_i.aw.addr[`AXIL_ADDR_WIDTH-1:IdxWidth+2];
  assign rd_err = |req_i.ar.addr[`AXIL_ADDR_WIDTH-1:IdxWidth+2];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `AXIL_NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_go && !wr_err) begin
      for (int lane = 0; lane < ByteLanes; lane++) begin
        if (req_i.w.strb[lane]) begin
          regs_q[wr_idx][8*lane +: 8] <= req_i.w.data[8*lane +: 8];
        end
      end
    end
  end

  // B slot
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      b_valid_q <= 1'b0;
    end else if (wr_go) begin
      b_valid_q <= 1'b1;
    end else if (req_i.b_ready) begin
      b_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_go) begin
      b_q.resp <= wr_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // R slot returns the value from before a same-cycle write
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      r_valid_q <= 1'b0;
    end else if (rd_go) begin
      r_valid_q <= 1'b1;
    end else if (req_i.r_ready) begin
      r_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_go) begin
      r_q.data <= rd_err ? '0 : regs_q[rd_idx];
      r_q.resp <= rd_err ? RESP_SLVERR : RESP_OKAY;
    end
  end

  always_comb begin
    rsp_o.aw_ready = wr_go;
    rsp_o.w_ready  = wr_go;
    rsp_o.b        = b_q;
    rsp_o.b_valid  = b_valid_q;
    rsp_o.ar_ready = rd_go;
    rsp_o.r        = r_q;
    rsp_o.r_valid  = r_valid_q;
  end

endmodule

// ==== hdl/axi_lite_link_top.sv ====
/*
  AXI4-Lite manager port reaching the register file through AXIL_NUM_CUTS cuts.
  Response latency grows by two cycles per cut.
*/
`include "axi_lite_consts.svh"

module axi_lite_link_top (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  axi_lite_pkg::axil_req_t req_i,
  output axi_lite_pkg::axil_rsp_t rsp_o
);
  import axi_lite_pkg::*;

  // Far end of the cut chain
  axil_req_t regfile_req;
  axil_rsp_t regfile_rsp;

  axi_lite_multicut #(
    .NumCuts (`AXIL_NUM_CUTS)
  ) i_multicut (
    .clk_i,
    .rst_i,
    .sbr_req_i (req_i),
    .sbr_rsp_o (rsp_o),
    .mgr_req_o (regfile_req),
    .mgr_rsp_i (regfile_rsp)
  );

  axi_lite_regfile i_regfile (
    .clk_i,
    .rst_i,
    .req_i (regfile_req),
    .rsp_o (regfile_rsp)
  );

endmodule

// ==== test/axi_lite_link_checker.sv ====
/*
  Handshake assertions on the top-level AXI4-Lite ports, attached by bind.
*/
module axi_lite_link_checker (
  input logic                    clk_i,
  input logic                    rst_i,
  input axi_lite_pkg::axil_req_t req_i,
  input axi_lite_pkg::axil_rsp_t rsp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Synchronous reset clears both response slots
  assert property (@(posedge clk_i) rst_i |=> !rsp_o.b_valid && !rsp_o.r_valid)
    else $error("response valid high after reset");

  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_o.b_valid && !req_i.b_ready |=> rsp_o.b_valid && $stable(rsp_o.b))
    else $error("B dropped or changed before b_ready");

  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_o.r_valid && !req_i.r_ready |=> rsp_o.r_valid && $stable(rsp_o.r))
    else $error("R dropped or changed before r_ready");

  // AW and W spill stages stay in lockstep
  assert property (@(posedge clk_i) disable iff (rst_i) rsp_o.aw_ready == rsp_o.w_ready)
    else $error("aw_ready and w_ready differ");

endmodule

bind axi_lite_link_top axi_lite_link_checker i_checker (
  .clk_i,
  .rst_i,
  .req_i,
  .rsp_o
);

// ==== test/axi_lite_link_tb.sv ====
/*
  Random AXI4-Lite traffic against a register model, driven on the falling edge.
  Assumes AW and W are always presented together and the top uses at least one cut.
*/
`include "axi_lite_consts.svh"

module axi_lite_link_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import axi_lite_pkg::*;

  localparam int Timeout = 200;

  logic      clk_i = 1'b0;
  logic      rst_i = 1'b1;
  axil_req_t req;
  axil_rsp_t rsp;

  data_t       model [`AXIL_NUM_REGS];
  logic [31:0] lcg_state = 32'h1a2b6dd2;
  int          err_count = 0;
  int          test_count = 0;
  int          test_errs;
  data_t       exp_rd_data [$];
  resp_t       exp_rd_resp [$];
  resp_t       exp_wr_resp [$];

  axi_lite_link_top uut (.clk_i, .rst_i, .req_i (req), .rsp_o (rsp));

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic in_range(addr_t addr);
    return (addr & 32'hffff_ffc0) == 32'h0;
  endfunction

  // Model update for a write with byte strobes and range check
  task automatic apply_write(input addr_t addr, input data_t data, input strb_t strb);
    if (in_range(addr)) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (strb[lane]) begin
          model[addr[5:2]][8*lane +: 8] = data[8*lane +: 8];
        end
      end
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      err_count++;
    end
  endtask

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected resp %0d, actual resp %0d", name, exp, act);
      err_count++;
    end
  endtask

  task automatic timeout_abort(input string what);
    $display("Timed out waiting for %s", what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %s: %0d errors", name, err_count - test_errs);
  endtask

  // Returns with valid still high, once the handshake is due at the next rising edge
  task automatic send_write(input addr_t addr, input data_t data, input strb_t strb);
    int waited;
    waited = 0;
    @(negedge clk_i);
    req.aw.addr  = addr;
    req.aw.prot  = '0;
    req.aw_valid = 1'b1;
    req.w.data   = data;
    req.w.strb   = strb;
    req.w_valid  = 1'b1;
    #1;
    while (!(rsp.aw_ready && rsp.w_ready)) begin
      waited++;
      if (waited > Timeout) timeout_abort("AW/W ready");
      @(negedge clk_i);
      #1;
    end
  endtask

  task automatic send_read(input addr_t addr);
    int waited;
    waited = 0;
    @(negedge clk_i);
    req.ar.addr  = addr;
    req.ar.prot  = '0;
    req.ar_valid = 1'b1;
    #1;
    while (!rsp.ar_ready) begin
      waited++;
      if (waited > Timeout) timeout_abort("AR ready");
      @(negedge clk_i);
      #1;
    end
  endtask

  // Random b_ready each cycle until a B transfer is due
  task automatic recv_b(output resp_t resp);
    int          waited;
    logic [31:0] rnd;
    waited = 0;
    forever begin
      @(negedge clk_i);
      rnd = next_rand();
      req.b_ready = rnd[4];
      #1;
      if (rsp.b_valid && req.b_ready) break;
      waited++;
      if (waited > Timeout) timeout_abort("B response");
    end
    resp = rsp.b.resp;
  endtask

  task automatic recv_r(output data_t data, output resp_t resp);
    int          waited;
    logic [31:0] rnd;
    waited = 0;
    forever begin
      @(negedge clk_i);
      rnd = next_rand();
      req.r_ready = rnd[7];
      #1;
      if (rsp.r_valid && req.r_ready) break;
      waited++;
      if (waited > Timeout) timeout_abort("R response");
    end
    data = rsp.r.data;
    resp = rsp.r.resp;
  endtask

  task automatic write_txn(input string name, input addr_t addr, input data_t data,
                           input strb_t strb);
    resp_t resp;
    send_write(addr, data, strb);
    @(negedge clk_i);
    req.aw_valid = 1'b0;
    req.w_valid  = 1'b0;
    apply_write(addr, data, strb);
    recv_b(resp);
    check_resp(name, in_range(addr) ? RESP_OKAY : RESP_SLVERR, resp);
  endtask

  task automatic read_txn(input string name, input addr_t addr);
    data_t data;
    resp_t resp;
    send_read(addr);
    @(negedge clk_i);
    req.ar_valid = 1'b0;
    recv_r(data, resp);
    check_data(name, in_range(addr) ? model[addr[5:2]] : '0, data);
    check_resp(name, in_range(addr) ? RESP_OKAY : RESP_SLVERR, resp);
  endtask

  initial begin
    addr_t addr;
    req = '0;
    for (int i = 0; i < `AXIL_NUM_REGS; i++) model[i] = '0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    test_errs = err_count;
    if (rsp.b_valid || rsp.r_valid) begin
      $display("Response valid high right after reset");
      err_count++;
    end
    for (int i = 0; i < 16; i++) read_txn("reset_state", addr_t'(i * 4));
    report_test("reset_state");

    test_errs = err_count;
    for (int i = 0; i < 24; i++) begin
      write_txn("write_readback", addr_t'(next_rand() & 32'h3c), next_rand(), 4'hf);
    end
    for (int i = 0; i < 16; i++) read_txn("write_readback", addr_t'(i * 4));
    report_test("write_readback");

    test_errs = err_count;
    for (int i = 0; i < 24; i++) begin
      addr = addr_t'(next_rand() & 32'h3f);
      write_txn("byte_strobes", addr, next_rand(), strb_t'(next_rand() >> 9));
      read_txn("byte_strobes", addr);
    end
    report_test("byte_strobes");

    test_errs = err_count;
    for (int i = 0; i < 8; i++) begin
      addr = addr_t'(next_rand() | 32'h40);
      write_txn("out_of_range", addr, next_rand(), 4'hf);
      read_txn("out_of_range", addr);
    end
    for (int i = 0; i < 16; i++) read_txn("out_of_range", addr_t'(i * 4));
    report_test("out_of_range");

    // Reads use registers 0..7 and writes 8..15, so their relative order does not matter
    test_errs = err_count;
    fork
      begin
        logic [31:0] rnd;
        for (int i = 0; i < 48; i++) begin
          addr = addr_t'(next_rand() & 32'h1c);
          rnd = next_rand();
          if (rnd[11:9] == 3'd0) addr = addr | 32'h100;
          send_read(addr);
          exp_rd_data.push_back(in_range(addr) ? model[addr[5:2]] : '0);
          exp_rd_resp.push_back(in_range(addr) ? RESP_OKAY : RESP_SLVERR);
        end
        @(negedge clk_i);
        req.ar_valid = 1'b0;
      end
      begin
        data_t d;
        resp_t r;
        for (int i = 0; i < 48; i++) begin
          recv_r(d, r);
          check_data("pipelined", exp_rd_data.pop_front(), d);
          check_resp("pipelined", exp_rd_resp.pop_front(), r);
        end
        @(negedge clk_i);
        req.r_ready = 1'b0;
      end
      begin
        addr_t       wa;
        data_t       wd;
        strb_t       ws;
        logic [31:0] rnd;
        for (int i = 0; i < 20; i++) begin
          wa = addr_t'((next_rand() & 32'h1c) | 32'h20);
          rnd = next_rand();
          if (rnd[13:11] == 3'd0) wa = wa | 32'h8000;
          wd = next_rand();
          ws = strb_t'(next_rand() >> 5);
          send_write(wa, wd, ws);
          apply_write(wa, wd, ws);
          exp_wr_resp.push_back(in_range(wa) ? RESP_OKAY : RESP_SLVERR);
        end
        @(negedge clk_i);
        req.aw_valid = 1'b0;
        req.w_valid  = 1'b0;
      end
      begin
        resp_t r;
        for (int i = 0; i < 20; i++) begin
          recv_b(r);
          check_resp("pipelined", exp_wr_resp.pop_front(), r);
        end
        @(negedge clk_i);
        req.b_ready = 1'b0;
      end
    join
    for (int i = 0; i < 16; i++) read_txn("pipelined", addr_t'(i * 4));
    report_test("pipelined");

    $display("%0d tests run, %0d errors", test_count, err_count);
    if (err_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== axi_lite_link.f ====
+incdir+hdl
hdl/axi_lite_pkg.sv
hdl/spill_register.sv
hdl/axi_lite_cut.sv
hdl/axi_lite_multicut.sv
hdl/axi_lite_regfile.sv
hdl/axi_lite_link_top.sv
test/axi_lite_link_checker.sv
test/axi_lite_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the AXI4-Lite link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module axi_lite_link_tb \
  -f axi_lite_link.f \
  -o axi_lite_link_sim

./obj_dir/axi_lite_link_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
else
  echo "simulation did not pass"
  exit 1
fi
